/* src/route_params.svh */
`ifndef ROUTE_PARAMS_SVH
`define ROUTE_PARAMS_SVH

// mesh size in routers
`define MESH_NX 4
`define MESH_NY 4

// router address field widths
`define MESH_XW ($clog2(`MESH_NX))
`define MESH_YW ($clog2(`MESH_NY))

`define MESH_PORTS 5  // local port plus four neighbours
`define DESTPORT_W 4  // compact code {x, y, a, b}

// odd-even placement
// 1: routing sits in the network interface, east-bound y turns skip the
// current-column parity check
`define OE_IN_NI 0

`endif

/* src/route_pkg.sv */
`include "route_params.svh"

package route_pkg;

    // port index, also the bit position inside port_mask_t
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    // routing algorithm opcode
    typedef enum logic [2:0] {
        ALGO_XY         = 3'd0,
        ALGO_WEST_FIRST = 3'd1,
        ALGO_NORTH_LAST = 3'd2,
        ALGO_NEG_FIRST  = 3'd3,
        ALGO_ODD_EVEN   = 3'd4
    } algo_e;

    typedef logic [`MESH_PORTS-1:0] port_mask_t;  // one bit per port_e

    typedef struct packed {
        logic [`MESH_XW-1:0] cur_x;
        logic [`MESH_YW-1:0] cur_y;
        logic [`MESH_XW-1:0] dst_x;
        logic [`MESH_YW-1:0] dst_y;
        algo_e               algo;
    } route_req_t;

    // decode stage output
    typedef struct packed {
        logic  x_plus;      // destination east of here
        logic  x_min;       // destination west of here
        logic  y_plus;      // destination south
        logic  y_min;       // destination north
        logic  cur_x_odd;
        logic  dst_x_odd;
        logic  x_one_step;  // destination exactly one column east
        algo_e algo;
    } dir_flags_t;

    typedef struct packed {
        port_mask_t mask;
        logic       x_plus;
        logic       y_min;
    } route_cand_t;

    typedef struct packed {
        port_mask_t             mask;
        logic [`DESTPORT_W-1:0] destport;  // {x, y, a, b}
    } route_resp_t;

endpackage

/* src/route_decode.sv */
`timescale 1ns/1ps
`include "route_params.svh"

// stage 1: address compare and column parity
module route_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  route_pkg::route_req_t req,
    output logic                  dir_valid,
    output route_pkg::dir_flags_t dir
);

    logic [`MESH_XW:0]     cur_x_east;  // column east of current, carry kept
    logic [`MESH_XW:0]     dst_x_ext;
    route_pkg::dir_flags_t dir_next;

    // extra msb so the east edge column never wraps onto column 0
    assign cur_x_east = {1'b0, req.cur_x} + 1'b1;
    assign dst_x_ext  = {1'b0, req.dst_x};

    always_comb begin
        dir_next.x_plus     = (req.dst_x > req.cur_x);
        dir_next.x_min      = (req.dst_x < req.cur_x);
        dir_next.y_plus     = (req.dst_y > req.cur_y);  // south grows y
        dir_next.y_min      = (req.dst_y < req.cur_y);
        dir_next.cur_x_odd  = req.cur_x[0];
        dir_next.dst_x_odd  = req.dst_x[0];
        dir_next.x_one_step = (dst_x_ext == cur_x_east);
        dir_next.algo       = req.algo;
    end

    // valid pipeline bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dir_valid <= 1'b0;
        end else begin
            dir_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dir <= dir_next;  // flags follow valid, captured every cycle
    end

endmodule

/* src/route_execute.sv */
`timescale 1ns/1ps
`include "route_params.svh"

// stage 2: allowed port set for the selected algorithm
module route_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dir_valid,
    input  route_pkg::dir_flags_t  dir,
    output logic                   cand_valid,
    output route_pkg::route_cand_t cand
);

    logic                   same_x;
    logic                   same_y;
    logic                   oe_y_ok;     // odd-even east-bound y turn allowed
    logic                   oe_east_ok;  // odd-even east step allowed
    route_pkg::port_mask_t  x_only;      // productive x port
    route_pkg::port_mask_t  y_only;      // productive y port
    route_pkg::port_mask_t  prod;        // all productive ports
    route_pkg::port_mask_t  xy_mask;
    route_pkg::port_mask_t  mask_next;
    route_pkg::route_cand_t cand_next;

    assign same_x = !dir.x_plus && !dir.x_min;
    assign same_y = !dir.y_plus && !dir.y_min;

    always_comb begin
        x_only = '0;
        x_only[route_pkg::EAST] = dir.x_plus;
        x_only[route_pkg::WEST] = dir.x_min;
    end

    always_comb begin
        y_only = '0;
        y_only[route_pkg::SOUTH] = dir.y_plus;
        y_only[route_pkg::NORTH] = dir.y_min;
    end

    assign prod = x_only | y_only;

    // dimension order, x first and a single port
    always_comb begin
        if (!same_x) begin
            xy_mask = x_only;
        end else begin
            xy_mask = y_only;
        end
    end

    // turn rules from the column parity
    assign oe_y_ok    = dir.cur_x_odd || (`OE_IN_NI != 0);
    assign oe_east_ok = dir.dst_x_odd || !dir.x_one_step;

    always_comb begin
        mask_next = prod;
        if (same_x && same_y) begin
            mask_next = '0;
            mask_next[route_pkg::LOCAL] = 1'b1;  // arrived
        end else begin
            case (dir.algo)
                route_pkg::ALGO_XY: begin
                    mask_next = xy_mask;
                end
                route_pkg::ALGO_WEST_FIRST: begin
                    if (dir.x_min) begin
                        mask_next = x_only;  // all west hops first
                    end
                end
                route_pkg::ALGO_NORTH_LAST: begin
                    // going north blocks any later x turn
                    if (dir.y_min && !same_x) begin
                        mask_next = x_only;
                    end
                end
                route_pkg::ALGO_NEG_FIRST: begin
                    if (dir.x_plus && dir.y_plus) begin
                        mask_next = y_only;  // south before east
                    end else if (dir.x_min && dir.y_min) begin
                        mask_next = x_only;  // west before north
                    end
                end
                route_pkg::ALGO_ODD_EVEN: begin
                    if (!same_x && !same_y) begin
                        if (dir.x_plus) begin
                            mask_next = (oe_y_ok ? y_only : '0) |
                                        (oe_east_ok ? x_only : '0);
                        end else begin
                            // west-bound, y turn only from even columns
                            mask_next = x_only | (dir.cur_x_odd ? '0 : y_only);
                        end
                    end
                end
                default: begin
                    mask_next = xy_mask;  // unused opcodes
                end
            endcase
        end
    end

    always_comb begin
        cand_next.mask   = mask_next;
        cand_next.x_plus = dir.x_plus;
        cand_next.y_min  = dir.y_min;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_valid <= 1'b0;
        end else begin
            cand_valid <= dir_valid;
        end
    end

    always_ff @(posedge clk) begin
        cand <= cand_next;
    end

endmodule

/* src/route_result.sv */
`timescale 1ns/1ps
`include "route_params.svh"

// stage 3: destination code and response register
module route_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cand_valid,
    input  route_pkg::route_cand_t cand,
    output logic                   out_valid,
    output route_pkg::route_resp_t resp
);

    logic                   a_bit;      // some x port allowed
    logic                   b_bit;      // some y port allowed
    logic [`DESTPORT_W-1:0] code_next;
    route_pkg::route_resp_t resp_next;

    assign a_bit = cand.mask[route_pkg::EAST] | cand.mask[route_pkg::WEST];
    assign b_bit = cand.mask[route_pkg::NORTH] | cand.mask[route_pkg::SOUTH];

    // {x, y, a, b}
    assign code_next = {cand.x_plus, cand.y_min, a_bit, b_bit};

    always_comb begin
        resp_next.mask     = cand.mask;
        resp_next.destport = code_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cand_valid;
        end
    end

    always_ff @(posedge clk) begin
        resp <= resp_next;
    end

endmodule

/* src/mesh_route_unit.sv */
`timescale 1ns/1ps

// three-stage route computation, one request per cycle
module mesh_route_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  route_pkg::route_req_t  req,
    output logic                   out_valid,
    output route_pkg::route_resp_t resp
);

    // decode to execute
    logic                   dir_valid;
    route_pkg::dir_flags_t  dir;

    // execute to result
    logic                   cand_valid;
    route_pkg::route_cand_t cand;

    route_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .dir_valid (dir_valid),
        .dir       (dir)
    );

    route_execute execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dir_valid  (dir_valid),
        .dir        (dir),
        .cand_valid (cand_valid),
        .cand       (cand)
    );

    route_result result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cand_valid (cand_valid),
        .cand       (cand),
        .out_valid  (out_valid),  // 3 cycles after in_valid
        .resp       (resp)
    );

endmodule

/* test/route_ref_model.svh */
`ifndef ROUTE_REF_MODEL_SVH
`define ROUTE_REF_MODEL_SVH

// productive directions or LOCAL alone on arrival
function automatic route_pkg::port_mask_t productive_ports(input route_pkg::route_req_t r);
    route_pkg::port_mask_t m;
    m = '0;
    if (r.dst_x > r.cur_x) begin
        m[route_pkg::EAST] = 1'b1;
    end
    if (r.dst_x < r.cur_x) begin
        m[route_pkg::WEST] = 1'b1;
    end
    if (r.dst_y > r.cur_y) begin
        m[route_pkg::SOUTH] = 1'b1;  // y grows southward
    end
    if (r.dst_y < r.cur_y) begin
        m[route_pkg::NORTH] = 1'b1;
    end
    if (m == '0) begin
        m[route_pkg::LOCAL] = 1'b1;
    end
    return m;
endfunction

// single port as a mask
function automatic route_pkg::port_mask_t one_port(input route_pkg::port_e p);
    route_pkg::port_mask_t m;
    m    = '0;
    m[p] = 1'b1;
    return m;
endfunction

// allowed port set per algorithm from the turn rules
function automatic route_pkg::port_mask_t expected_mask(input route_pkg::route_req_t r);
    route_pkg::port_mask_t prod;
    route_pkg::port_mask_t m;
    route_pkg::port_e      x_port;
    route_pkg::port_e      y_port;
    logic                  x_diff;
    logic                  y_diff;
    prod   = productive_ports(r);
    x_diff = (r.dst_x != r.cur_x);
    y_diff = (r.dst_y != r.cur_y);
    x_port = (r.dst_x > r.cur_x) ? route_pkg::EAST : route_pkg::WEST;
    y_port = (r.dst_y > r.cur_y) ? route_pkg::SOUTH : route_pkg::NORTH;
    m      = '0;
    if (prod[route_pkg::LOCAL]) begin
        m = prod;
    end else begin
        case (r.algo)
            route_pkg::ALGO_XY: begin
                m[x_diff ? x_port : y_port] = 1'b1;
            end
            route_pkg::ALGO_WEST_FIRST: begin
                m = (x_port == route_pkg::WEST && x_diff) ? one_port(route_pkg::WEST) : prod;
            end
            route_pkg::ALGO_NORTH_LAST: begin
                m = (y_port == route_pkg::NORTH && y_diff && x_diff) ? one_port(x_port) : prod;
            end
            route_pkg::ALGO_NEG_FIRST: begin
                m = prod;
                if (x_diff && y_diff && x_port == route_pkg::EAST &&
                    y_port == route_pkg::SOUTH) begin
                    m = one_port(route_pkg::SOUTH);
                end
                if (x_diff && y_diff && x_port == route_pkg::WEST &&
                    y_port == route_pkg::NORTH) begin
                    m = one_port(route_pkg::WEST);
                end
            end
            route_pkg::ALGO_ODD_EVEN: begin
                m = prod;
                if (x_diff && y_diff && x_port == route_pkg::EAST) begin
                    m = '0;
                    if (r.cur_x[0] || (`OE_IN_NI != 0)) begin
                        m[y_port] = 1'b1;
                    end
                    if (r.dst_x[0] || (int'(r.dst_x) != int'(r.cur_x) + 1)) begin
                        m[route_pkg::EAST] = 1'b1;
                    end
                end else if (x_diff && y_diff) begin
                    m = one_port(route_pkg::WEST);
                    m[y_port] = !r.cur_x[0];  // even column may turn
                end
            end
            default: begin
                m = prod;
            end
        endcase
    end
    return m;
endfunction

// {x, y, a, b} from the request and the allowed set
function automatic logic [`DESTPORT_W-1:0] expected_destport(input route_pkg::route_req_t r,
                                                             input route_pkg::port_mask_t m);
    return {r.dst_x > r.cur_x, r.dst_y < r.cur_y,
            m[route_pkg::EAST] | m[route_pkg::WEST],
            m[route_pkg::NORTH] | m[route_pkg::SOUTH]};
endfunction

`endif

/* test/tb_mesh_route.sv */
`timescale 1ns/1ps
`include "route_params.svh"

module tb_mesh_route;

    localparam int N_DIRECTED  = 5 * `MESH_NX * `MESH_NY * `MESH_NX * `MESH_NY;
    localparam int N_RANDOM    = 300;
    localparam int CYCLE_LIMIT = N_DIRECTED + N_RANDOM + 2000;

    typedef struct packed {
        route_pkg::route_req_t  req;
        route_pkg::port_mask_t  prod;  // productive set, for the subset check
        route_pkg::route_resp_t resp;
    } exp_item_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    route_pkg::route_req_t  req;
    logic                   out_valid;
    route_pkg::route_resp_t resp;

    exp_item_t  exp_q[$];
    exp_item_t  cur_exp;
    logic       exp_ok      = 1'b0;
    logic [2:0] vld_hist    = '0;  // in_valid delayed by the pipeline depth
    logic       timed_out   = 1'b0;
    int         error_count = 0;
    int         sent_count  = 0;
    int         resp_count  = 0;
    int         cycle_count = 0;
    integer     seed        = 60;

`include "route_ref_model.svh"

    mesh_route_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .resp      (resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            vld_hist <= '0;
        end else begin
            vld_hist <= {vld_hist[1:0], in_valid};
        end
    end

    // take the matching expectation mid-cycle while resp is steady
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            resp_count++;
            if (exp_q.size() != 0) begin
                cur_exp = exp_q.pop_front();
                exp_ok  = 1'b1;
            end else begin
                exp_ok = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid == vld_hist[2])
        else begin
            error_count++;
            $display("[FAIL] out_valid got %h expected %h",
                     $sampled(out_valid), $sampled(vld_hist[2]));
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> exp_ok)
        else begin
            error_count++;
            $display("a response came out with no request pending");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     out_valid && exp_ok |-> resp.mask == cur_exp.resp.mask)
        else begin
            error_count++;
            $display("[FAIL] resp.mask got %h expected %h (req %h)",
                     $sampled(resp.mask), $sampled(cur_exp.resp.mask), $sampled(cur_exp.req));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     out_valid && exp_ok |-> resp.destport == cur_exp.resp.destport)
        else begin
            error_count++;
            $display("[FAIL] resp.destport got %h expected %h (req %h)",
                     $sampled(resp.destport), $sampled(cur_exp.resp.destport),
                     $sampled(cur_exp.req));
        end

    // xy names exactly one port
    assert property (@(posedge clk) disable iff (!rst_n)
                     out_valid && exp_ok && cur_exp.req.algo == route_pkg::ALGO_XY
                     |-> $onehot(resp.mask))
        else begin
            error_count++;
            $display("[FAIL] resp.mask not one-hot for xy, got %h", $sampled(resp.mask));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     out_valid && exp_ok |-> (resp.mask & ~cur_exp.prod) == '0)
        else begin
            error_count++;
            $display("[FAIL] resp.mask got %h outside productive set %h",
                     $sampled(resp.mask), $sampled(cur_exp.prod));
        end

    function automatic exp_item_t make_expectation(input route_pkg::route_req_t r);
        exp_item_t e;
        e.req           = r;
        e.prod          = productive_ports(r);
        e.resp.mask     = expected_mask(r);
        e.resp.destport = expected_destport(r, e.resp.mask);
        return e;
    endfunction

    task automatic send_request(input route_pkg::route_req_t r);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        req      = r;
        exp_q.push_back(make_expectation(r));
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // every current/destination pair, back to back
    task automatic sweep_algorithm(input route_pkg::algo_e a);
        route_pkg::route_req_t r;
        r.algo = a;
        for (int cx = 0; cx < `MESH_NX; cx++) begin
            for (int cy = 0; cy < `MESH_NY; cy++) begin
                for (int dx = 0; dx < `MESH_NX; dx++) begin
                    for (int dy = 0; dy < `MESH_NY; dy++) begin
                        r.cur_x = cx[`MESH_XW-1:0];
                        r.cur_y = cy[`MESH_YW-1:0];
                        r.dst_x = dx[`MESH_XW-1:0];
                        r.dst_y = dy[`MESH_YW-1:0];
                        send_request(r);
                    end
                end
            end
        end
    endtask

    task automatic random_requests(input int count);
        logic [31:0]           rnd;
        route_pkg::route_req_t r;
        for (int i = 0; i < count; i++) begin
            rnd     = $random(seed);
            r.cur_x = rnd[0+:`MESH_XW];
            r.cur_y = rnd[8+:`MESH_YW];
            r.dst_x = rnd[16+:`MESH_XW];
            r.dst_y = rnd[24+:`MESH_YW];
            r.algo  = route_pkg::algo_e'(rnd[31:29] % 3'd5);
            send_request(r);
            if (rnd[4:3] == 2'b00) begin
                repeat (1 + rnd[5]) idle_cycle();  // short gap
            end
        end
    endtask

    task automatic report_and_finish();
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected responses never came out", exp_q.size());
        end
        $display("errors: %0d, requests sent: %0d, responses seen: %0d",
                 error_count, sent_count, resp_count);
        if (error_count == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d clock cycles", CYCLE_LIMIT);
        timed_out = 1'b1;
        report_and_finish();
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int a = 0; a < 5; a++) begin
            sweep_algorithm(route_pkg::algo_e'(a[2:0]));
        end
        idle_cycle();
        random_requests(N_RANDOM);
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // quiet tail, no stray out_valid
        report_and_finish();
    end

endmodule

/* flist.f */
+incdir+src
+incdir+test
src/route_pkg.sv
src/route_decode.sv
src/route_execute.sv
src/route_result.sv
src/mesh_route_unit.sv
test/tb_mesh_route.sv
